/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/mem_stage_defines.svh */
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// data word width in bits
`define MEM_XLEN 32

// data RAM depth in words, upper address bits wrap
`define MEM_WORDS 256

`endif

/* common/mem_stage_pkg.sv */
`include "mem_stage_defines.svh"

package mem_stage_pkg;

    // data or address word
    typedef logic [`MEM_XLEN-1:0] word_t;

    // integer register index, x0 never written
    typedef logic [4:0] reg_idx_t;

    // CSR address, 0 means no write
    typedef logic [11:0] csr_addr_t;

    // one bit per byte lane
    // unshifted at issue: 0001 byte, 0011 half, 1111 word
    typedef logic [`MEM_XLEN/8-1:0] strb_t;

endpackage

/* files.f */
+incdir+common
common/mem_stage_pkg.sv
mem_stage/mread.sv
mem_stage/mwrite.sv
hdl/data_mem.sv
hdl/mem_subsys_top.sv
testbench/mem_subsys_sva.sv
testbench/mem_subsys_tb.sv

/* hdl/data_mem.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module data_mem
    import mem_stage_pkg::*;
(
    input  logic  CLK,
    input  logic  rst_n,
    input  logic  mem_wait,
    input  logic  rd_en,
    input  word_t rd_addr,
    output word_t rd_data,
    input  logic  wr_en,
    input  word_t wr_addr,
    input  word_t wr_data
);

    localparam int OFS_W = $clog2(`MEM_XLEN / 8);
    localparam int IDX_W = $clog2(`MEM_WORDS);

    word_t            mem [`MEM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_fire;

    // byte offset dropped, upper bits wrap
    assign rd_idx  = rd_addr[OFS_W +: IDX_W];
    assign wr_idx  = wr_addr[OFS_W +: IDX_W];
    assign wr_fire = wr_en && !mem_wait;

    always_ff @(posedge CLK) begin
        if (wr_fire) begin
            mem[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en && !mem_wait) begin
            // write-first on a same-word collision
            if (wr_fire && (wr_idx == rd_idx)) begin
                rd_data <= wr_data;
            end else begin
                rd_data <= mem[rd_idx];
            end
        end
    end

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top
    import mem_stage_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      mem_wait,

    input  reg_idx_t  iss_reg_rd,
    input  word_t     iss_reg_data,
    input  csr_addr_t iss_csr_addr,
    input  word_t     iss_csr_data,
    input  logic      iss_ld_valid,
    input  reg_idx_t  iss_ld_rd,
    input  word_t     iss_ld_addr,
    input  strb_t     iss_ld_strb,
    input  logic      iss_ld_signed,
    input  logic      iss_st_valid,
    input  word_t     iss_st_addr,
    input  strb_t     iss_st_strb,
    input  word_t     iss_st_data,
    input  logic      iss_jmp_do,
    input  word_t     iss_jmp_pc,

    output logic      wb_valid,
    output reg_idx_t  wb_rd,
    output word_t     wb_data,
    output logic      csr_valid,
    output csr_addr_t csr_addr,
    output word_t     csr_data,
    output logic      jmp_do,
    output word_t     jmp_pc,
    output logic      st_commit,
    output word_t     st_addr,
    output word_t     st_data
);

    logic      rd_en;
    word_t     rd_addr;
    word_t     rd_data;

    reg_idx_t  memr_reg_rd;
    word_t     memr_reg_data;
    csr_addr_t memr_csr_addr;
    word_t     memr_csr_data;
    logic      memr_st_valid;
    word_t     memr_st_addr;
    strb_t     memr_st_strb;
    word_t     memr_st_data;
    logic      memr_jmp_do;
    word_t     memr_jmp_pc;

    mread mread_i (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .flush         (flush),
        .mem_wait      (mem_wait),
        .iss_reg_rd    (iss_reg_rd),
        .iss_reg_data  (iss_reg_data),
        .iss_csr_addr  (iss_csr_addr),
        .iss_csr_data  (iss_csr_data),
        .iss_ld_valid  (iss_ld_valid),
        .iss_ld_rd     (iss_ld_rd),
        .iss_ld_addr   (iss_ld_addr),
        .iss_ld_strb   (iss_ld_strb),
        .iss_ld_signed (iss_ld_signed),
        .iss_st_valid  (iss_st_valid),
        .iss_st_addr   (iss_st_addr),
        .iss_st_strb   (iss_st_strb),
        .iss_st_data   (iss_st_data),
        .iss_jmp_do    (iss_jmp_do),
        .iss_jmp_pc    (iss_jmp_pc),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .memr_reg_rd   (memr_reg_rd),
        .memr_reg_data (memr_reg_data),
        .memr_csr_addr (memr_csr_addr),
        .memr_csr_data (memr_csr_data),
        .memr_st_valid (memr_st_valid),
        .memr_st_addr  (memr_st_addr),
        .memr_st_strb  (memr_st_strb),
        .memr_st_data  (memr_st_data),
        .memr_jmp_do   (memr_jmp_do),
        .memr_jmp_pc   (memr_jmp_pc)
    );

    // merged store goes out as a whole word
    data_mem data_mem_i (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .mem_wait (mem_wait),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .wr_en    (memr_st_valid),
        .wr_addr  (memr_st_addr),
        .wr_data  (memr_st_data)
    );

    mwrite mwrite_i (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .mem_wait      (mem_wait),
        .memr_reg_rd   (memr_reg_rd),
        .memr_reg_data (memr_reg_data),
        .memr_csr_addr (memr_csr_addr),
        .memr_csr_data (memr_csr_data),
        .memr_st_valid (memr_st_valid),
        .memr_st_addr  (memr_st_addr),
        .memr_st_strb  (memr_st_strb),
        .memr_st_data  (memr_st_data),
        .memr_jmp_do   (memr_jmp_do),
        .memr_jmp_pc   (memr_jmp_pc),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .csr_valid     (csr_valid),
        .csr_addr      (csr_addr),
        .csr_data      (csr_data),
        .jmp_do        (jmp_do),
        .jmp_pc        (jmp_pc),
        .st_commit     (st_commit),
        .st_addr       (st_addr),
        .st_data       (st_data)
    );

endmodule

/* mem_stage/mread.sv */
`timescale 1ns/1ps

module mread
    import mem_stage_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      mem_wait,

    // issue side
    input  reg_idx_t  iss_reg_rd,
    input  word_t     iss_reg_data,
    input  csr_addr_t iss_csr_addr,
    input  word_t     iss_csr_data,
    input  logic      iss_ld_valid,
    input  reg_idx_t  iss_ld_rd,
    input  word_t     iss_ld_addr,
    input  strb_t     iss_ld_strb,
    input  logic      iss_ld_signed,
    input  logic      iss_st_valid,
    input  word_t     iss_st_addr,
    input  strb_t     iss_st_strb,
    input  word_t     iss_st_data,
    input  logic      iss_jmp_do,
    input  word_t     iss_jmp_pc,

    // data RAM read port
    output logic      rd_en,
    output word_t     rd_addr,
    input  word_t     rd_data,

    // towards mwrite and the RAM write port
    output reg_idx_t  memr_reg_rd,
    output word_t     memr_reg_data,
    output csr_addr_t memr_csr_addr,
    output word_t     memr_csr_data,
    output logic      memr_st_valid,
    output word_t     memr_st_addr,
    output strb_t     memr_st_strb,
    output word_t     memr_st_data,
    output logic      memr_jmp_do,
    output word_t     memr_jmp_pc
);

    reg_idx_t   reg_rd_q;
    word_t      reg_data_q;
    csr_addr_t  csr_addr_q;
    word_t      csr_data_q;
    logic       ld_valid_q;
    reg_idx_t   ld_rd_q;
    logic [1:0] ld_ofs_q;
    strb_t      ld_strb_q;
    logic       ld_signed_q;
    logic       st_valid_q;
    word_t      st_addr_q;
    strb_t      st_strb_q;
    word_t      st_data_q;
    logic       jmp_do_q;
    word_t      jmp_pc_q;

    strb_t      ld_strb_sh;
    strb_t      st_strb_sh;
    word_t      ld_word;

    // loads and the old word of a store share the one read port
    assign rd_en   = iss_ld_valid | iss_st_valid;
    assign rd_addr = iss_ld_valid ? iss_ld_addr : iss_st_addr;

    always_ff @(posedge CLK) begin
        if (!rst_n || (flush && !mem_wait)) begin
            reg_rd_q    <= '0;
            reg_data_q  <= '0;
            csr_addr_q  <= '0;
            csr_data_q  <= '0;
            ld_valid_q  <= 1'b0;
            ld_rd_q     <= '0;
            ld_ofs_q    <= '0;
            ld_strb_q   <= '0;
            ld_signed_q <= 1'b0;
            st_valid_q  <= 1'b0;
            st_addr_q   <= '0;
            st_strb_q   <= '0;
            st_data_q   <= '0;
            jmp_do_q    <= 1'b0;
            jmp_pc_q    <= '0;
        end else if (!mem_wait) begin
            reg_rd_q    <= iss_reg_rd;
            reg_data_q  <= iss_reg_data;
            csr_addr_q  <= iss_csr_addr;
            csr_data_q  <= iss_csr_data;
            ld_valid_q  <= iss_ld_valid;
            ld_rd_q     <= iss_ld_rd;
            ld_ofs_q    <= iss_ld_addr[1:0];
            ld_strb_q   <= iss_ld_strb;
            ld_signed_q <= iss_ld_signed;
            st_valid_q  <= iss_st_valid;
            st_addr_q   <= iss_st_addr;
            st_strb_q   <= iss_st_strb;
            st_data_q   <= iss_st_data;
            jmp_do_q    <= iss_jmp_do;
            jmp_pc_q    <= iss_jmp_pc;
        end
    end

    // pick the lane named by the shifted strobe, extend to a full word
    function automatic word_t load_lane(word_t data, strb_t strb, logic sgn);
        word_t res;
        case (strb)
            4'b0001: res = {{24{sgn & data[7]}},  data[7:0]};
            4'b0010: res = {{24{sgn & data[15]}}, data[15:8]};
            4'b0100: res = {{24{sgn & data[23]}}, data[23:16]};
            4'b1000: res = {{24{sgn & data[31]}}, data[31:24]};
            4'b0011: res = {{16{sgn & data[15]}}, data[15:0]};
            4'b0110: res = {{16{sgn & data[23]}}, data[23:8]};
            4'b1100: res = {{16{sgn & data[31]}}, data[31:16]};
            default: res = data;
        endcase
        return res;
    endfunction

    // store data already sits in its byte lanes
    function automatic word_t store_merge(word_t old, word_t src, strb_t strb);
        word_t mask;
        case (strb)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b0110, 4'b1100:
                mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            default:
                mask = '1;
        endcase
        return (old & ~mask) | (src & mask);
    endfunction

    assign ld_strb_sh = ld_strb_q << ld_ofs_q;
    assign st_strb_sh = st_strb_q << st_addr_q[1:0];
    assign ld_word    = load_lane(rd_data, ld_strb_sh, ld_signed_q);

    // a load takes over the register writeback
    assign memr_reg_rd   = ld_valid_q ? ld_rd_q : reg_rd_q;
    assign memr_reg_data = ld_valid_q ? ld_word : reg_data_q;
    assign memr_csr_addr = csr_addr_q;
    assign memr_csr_data = csr_data_q;

    // an empty strobe writes nothing
    assign memr_st_valid = st_valid_q && (st_strb_q != '0);
    assign memr_st_addr  = st_addr_q;
    assign memr_st_strb  = st_strb_sh;
    assign memr_st_data  = store_merge(rd_data, st_data_q, st_strb_sh);
    assign memr_jmp_do   = jmp_do_q;
    assign memr_jmp_pc   = jmp_pc_q;

endmodule

/* mem_stage/mwrite.sv */
`timescale 1ns/1ps

module mwrite
    import mem_stage_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      mem_wait,

    // from mread
    input  reg_idx_t  memr_reg_rd,
    input  word_t     memr_reg_data,
    input  csr_addr_t memr_csr_addr,
    input  word_t     memr_csr_data,
    input  logic      memr_st_valid,
    input  word_t     memr_st_addr,
    input  strb_t     memr_st_strb,
    input  word_t     memr_st_data,
    input  logic      memr_jmp_do,
    input  word_t     memr_jmp_pc,

    // results
    output logic      wb_valid,
    output reg_idx_t  wb_rd,
    output word_t     wb_data,
    output logic      csr_valid,
    output csr_addr_t csr_addr,
    output word_t     csr_data,
    output logic      jmp_do,
    output word_t     jmp_pc,
    output logic      st_commit,
    output word_t     st_addr,
    output word_t     st_data
);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            wb_rd     <= '0;
            wb_data   <= '0;
            csr_valid <= 1'b0;
            csr_addr  <= '0;
            csr_data  <= '0;
            jmp_do    <= 1'b0;
            jmp_pc    <= '0;
            st_commit <= 1'b0;
            st_addr   <= '0;
            st_data   <= '0;
        end else if (!mem_wait) begin
            // x0 and CSR 0 are no-ops
            wb_valid  <= (memr_reg_rd != '0);
            wb_rd     <= memr_reg_rd;
            wb_data   <= memr_reg_data;
            csr_valid <= (memr_csr_addr != '0);
            csr_addr  <= memr_csr_addr;
            csr_data  <= memr_csr_data;
            jmp_do    <= memr_jmp_do;
            jmp_pc    <= memr_jmp_pc;
            // same condition the RAM write saw
            st_commit <= memr_st_valid;
            st_addr   <= memr_st_addr;
            st_data   <= memr_st_data;
        end
    end

endmodule

/* testbench/mem_subsys_sva.sv */
`timescale 1ns/1ps

module mem_subsys_sva
    import mem_stage_pkg::*;
(
    input logic      CLK,
    input logic      rst_n,
    input logic      mem_wait,
    input logic      wb_valid,
    input reg_idx_t  wb_rd,
    input word_t     wb_data,
    input logic      csr_valid,
    input csr_addr_t csr_addr,
    input word_t     csr_data,
    input logic      jmp_do,
    input word_t     jmp_pc,
    input logic      st_commit,
    input word_t     st_addr,
    input word_t     st_data
);

    // a stalled edge leaves every output as it was
    stall_hold: assert property (@(posedge CLK)
        rst_n && mem_wait |=> $stable({wb_valid, wb_rd, wb_data, csr_valid, csr_addr,
            csr_data, jmp_do, jmp_pc, st_commit, st_addr, st_data}))
        else $error("outputs changed across a stalled edge");

    // x0 is never reported
    wb_rd_nonzero: assert property (@(posedge CLK) wb_valid |-> wb_rd != '0)
        else $error("wb_valid with wb_rd zero");

    reset_quiet: assert property (@(posedge CLK)
        !rst_n |=> !wb_valid && !csr_valid && !jmp_do && !st_commit)
        else $error("control output high after a reset edge");

endmodule

bind mem_subsys_top mem_subsys_sva sva_i (.*);

/* testbench/mem_subsys_tb.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_subsys_tb
    import mem_stage_pkg::*;
();

    localparam int RST_CYCLES  = 10;
    localparam int N_RAND      = 200;
    localparam int N_PLAIN     = 150;
    localparam int N_MIX       = 300;
    localparam int TEST_CYCLES = RST_CYCLES + 2 * `MEM_WORDS + 2 * N_RAND + N_PLAIN + N_MIX + 10;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    // expected contents of one pipeline stage
    typedef struct packed {
        reg_idx_t  rd;
        word_t     wdata;
        csr_addr_t csr_a;
        word_t     csr_d;
        logic      jmp;
        word_t     pc;
        logic      st;
        word_t     st_addr;
        word_t     st_data;
    } exp_t;

    logic      CLK;
    logic      rst_n;
    logic      flush;
    logic      mem_wait;
    reg_idx_t  iss_reg_rd;
    reg_idx_t  iss_ld_rd;
    csr_addr_t iss_csr_addr;
    word_t     iss_reg_data;
    word_t     iss_csr_data;
    word_t     iss_ld_addr;
    word_t     iss_st_addr;
    word_t     iss_st_data;
    word_t     iss_jmp_pc;
    strb_t     iss_ld_strb;
    strb_t     iss_st_strb;
    logic      iss_ld_valid;
    logic      iss_ld_signed;
    logic      iss_st_valid;
    logic      iss_jmp_do;
    logic      wb_valid;
    logic      csr_valid;
    logic      jmp_do;
    logic      st_commit;
    reg_idx_t  wb_rd;
    csr_addr_t csr_addr;
    word_t     wb_data;
    word_t     csr_data;
    word_t     jmp_pc;
    word_t     st_addr;
    word_t     st_data;

    logic [31:0] lcg_state;
    word_t       model_mem [`MEM_WORDS];
    exp_t        s1;
    exp_t        s2;
    int          errors = 0;
    int          n_tests = 0;
    int          n_failed = 0;
    int          cycle_cnt = 0;

    mem_subsys_top dut_i (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // random upper bits exercise address wrap
    function automatic word_t make_addr(int unsigned widx, logic [1:0] ofs);
        word_t hi;
        hi = next_rand();
        return (hi & ~word_t'(4 * `MEM_WORDS - 1)) | word_t'(4 * (widx % `MEM_WORDS))
            | word_t'(ofs);
    endfunction

    function automatic int word_index(word_t a);
        return int'((a >> 2) % `MEM_WORDS);
    endfunction

    function automatic bit lanes_legal(strb_t sh);
        return sh inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b0110, 4'b1100};
    endfunction

    function automatic word_t load_expect(word_t w, word_t a, strb_t strb, logic sgn);
        strb_t sh;
        int    i;
        int    lo;
        int    nb;
        word_t v;
        sh = strb << a[1:0];
        if (!lanes_legal(sh)) return w;
        lo = 0;
        nb = 0;
        for (i = 3; i >= 0; i--) begin
            if (sh[i]) begin
                lo = i;
                nb++;
            end
        end
        v = w >> (8 * lo);
        if (nb == 1) return sgn ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
        return sgn ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
    endfunction

    function automatic word_t store_expect(word_t old, word_t src, word_t a, strb_t strb);
        strb_t sh;
        word_t res;
        int    i;
        sh = strb << a[1:0];
        if (!lanes_legal(sh)) return src;
        res = old;
        for (i = 0; i < 4; i++) begin
            if (sh[i]) res[8*i +: 8] = src[8*i +: 8];
        end
        return res;
    endfunction

    task automatic report(string sig, word_t got, word_t exp);
        $display("Error at %0t ns: %s = 0x%h, expected 0x%h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic check_wb(reg_idx_t rd, word_t data);
        if (wb_valid !== (rd != '0)) report("wb_valid", word_t'(wb_valid), word_t'(rd != '0));
        if (wb_rd !== rd) report("wb_rd", word_t'(wb_rd), word_t'(rd));
        if (wb_data !== data) report("wb_data", wb_data, data);
    endtask

    task automatic check_csr(csr_addr_t addr, word_t data);
        if (csr_valid !== (addr != '0)) report("csr_valid", word_t'(csr_valid), word_t'(addr != '0));
        if (csr_addr !== addr) report("csr_addr", word_t'(csr_addr), word_t'(addr));
        if (csr_data !== data) report("csr_data", csr_data, data);
    endtask

    task automatic check_jmp(logic exp_do, word_t pc);
        if (jmp_do !== exp_do) report("jmp_do", word_t'(jmp_do), word_t'(exp_do));
        if (jmp_pc !== pc) report("jmp_pc", jmp_pc, pc);
    endtask

    task automatic check_store(word_t addr, word_t data);
        if (st_addr !== addr) report("st_addr", st_addr, addr);
        if (st_data !== data) report("st_data", st_data, data);
    endtask

    // model follows the edge, outputs are compared half a cycle later
    task automatic tick();
        exp_t nxt;
        @(posedge CLK);
        if (!rst_n) begin
            s1 = '0;
            s2 = '0;
        end else if (!mem_wait) begin
            nxt = '0;
            if (!flush) begin
                nxt.rd    = iss_ld_valid ? iss_ld_rd : iss_reg_rd;
                nxt.wdata = iss_ld_valid ? load_expect(model_mem[word_index(iss_ld_addr)],
                    iss_ld_addr, iss_ld_strb, iss_ld_signed) : iss_reg_data;
                nxt.csr_a = iss_csr_addr;
                nxt.csr_d = iss_csr_data;
                nxt.jmp   = iss_jmp_do;
                nxt.pc    = iss_jmp_pc;
                if (iss_st_valid && iss_st_strb != '0) begin
                    nxt.st      = 1'b1;
                    nxt.st_addr = iss_st_addr;
                    nxt.st_data = store_expect(model_mem[word_index(iss_st_addr)], iss_st_data,
                        iss_st_addr, iss_st_strb);
                    model_mem[word_index(iss_st_addr)] = nxt.st_data;
                end
            end
            s2 = s1;
            s1 = nxt;
        end
        @(negedge CLK);
        check_wb(s2.rd, s2.wdata);
        check_csr(s2.csr_a, s2.csr_d);
        check_jmp(s2.jmp, s2.pc);
        if (st_commit !== s2.st) report("st_commit", word_t'(st_commit), word_t'(s2.st));
        else if (s2.st) check_store(s2.st_addr, s2.st_data);
    endtask

    task automatic clear_issue();
        iss_reg_rd    = '0;
        iss_reg_data  = '0;
        iss_csr_addr  = '0;
        iss_csr_data  = '0;
        iss_ld_valid  = 1'b0;
        iss_ld_rd     = '0;
        iss_ld_addr   = '0;
        iss_ld_strb   = '0;
        iss_ld_signed = 1'b0;
        iss_st_valid  = 1'b0;
        iss_st_addr   = '0;
        iss_st_strb   = '0;
        iss_st_data   = '0;
        iss_jmp_do    = 1'b0;
        iss_jmp_pc    = '0;
    endtask

    task automatic set_load(reg_idx_t rd, word_t addr, strb_t strb, logic sgn);
        clear_issue();
        iss_ld_valid  = 1'b1;
        iss_ld_rd     = rd;
        iss_ld_addr   = addr;
        iss_ld_strb   = strb;
        iss_ld_signed = sgn;
    endtask

    task automatic set_store(word_t addr, strb_t strb, word_t data);
        clear_issue();
        iss_st_valid = 1'b1;
        iss_st_addr  = addr;
        iss_st_strb  = strb;
        iss_st_data  = data;
    endtask

    // inputs stay put until an edge without mem_wait takes them
    task automatic send(bit allow_wait, bit allow_flush);
        logic [31:0] r;
        r = next_rand();
        flush = allow_flush && (r[31:29] == 3'd0);
        do begin
            r = next_rand();
            mem_wait = allow_wait && (r[31:30] == 2'd0);
            tick();
        end while (mem_wait);
        flush = 1'b0;
    endtask

    task automatic drain();
        clear_issue();
        send(1'b0, 1'b0);
        send(1'b0, 1'b0);
    endtask

    task automatic random_access(bit allow_store, int unsigned span);
        logic [31:0] r;
        logic [1:0]  ofs;
        strb_t       strb;
        word_t       addr;
        r = next_rand();
        if (r[31]) begin
            strb = 4'b0001;
            ofs  = r[29:28];
        end else begin
            strb = 4'b0011;
            ofs  = (r[29:28] == 2'd3) ? 2'd1 : r[29:28];
        end
        addr = make_addr((r >> 16) % span, ofs);
        if (allow_store && r[30]) set_store(addr, strb, next_rand());
        else set_load(r[26:22], addr, strb, r[27]);
    endtask

    task automatic random_plain();
        logic [31:0] r;
        logic [31:0] q;
        r = next_rand();
        q = next_rand();
        clear_issue();
        iss_reg_rd   = r[26] ? r[31:27] : '0;
        iss_reg_data = next_rand();
        iss_csr_addr = r[25] ? r[24:13] : '0;
        iss_csr_data = next_rand();
        iss_jmp_do   = q[31];
        iss_jmp_pc   = next_rand();
        // a load takes over rd and data
        if (q[30:29] == 2'd0) begin
            iss_ld_valid = 1'b1;
            iss_ld_rd    = q[28:24];
            iss_ld_addr  = make_addr(q >> 8, 2'b00);
            iss_ld_strb  = 4'b1111;
        end
    endtask

    task automatic end_test(string name, int base);
        n_tests++;
        if (errors != base) n_failed++;
        $display("test %0d %s: %s, %0d errors", n_tests, name,
            (errors == base) ? "ok" : "mismatches", errors - base);
    endtask

    initial begin
        int i;
        int base;
        CLK       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        mem_wait  = 1'b0;
        lcg_state = 32'hbaeaec16;
        s1        = '0;
        s2        = '0;
        clear_issue();
        repeat (RST_CYCLES) tick();
        rst_n = 1'b1;

        base = errors;
        for (i = 0; i < `MEM_WORDS; i++) begin
            set_store(make_addr(i, 2'b00), 4'b1111, next_rand());
            send(1'b0, 1'b0);
        end
        for (i = 0; i < `MEM_WORDS; i++) begin
            set_load(reg_idx_t'(i % 31 + 1), make_addr(i, 2'b00), 4'b1111, 1'b0);
            send(1'b0, 1'b0);
        end
        drain();
        end_test("word fill and readback", base);

        base = errors;
        for (i = 0; i < N_RAND; i++) begin
            random_access(1'b0, `MEM_WORDS);
            send(1'b0, 1'b0);
        end
        drain();
        end_test("byte and half loads", base);

        // few words, so stores and loads collide
        base = errors;
        for (i = 0; i < N_RAND; i++) begin
            random_access(1'b1, 4);
            send(1'b0, 1'b0);
        end
        drain();
        end_test("partial stores and forwarding", base);

        base = errors;
        for (i = 0; i < N_PLAIN; i++) begin
            random_plain();
            send(1'b0, 1'b0);
        end
        drain();
        end_test("register, csr and jump", base);

        base = errors;
        for (i = 0; i < N_MIX; i++) begin
            if (next_rand() > 32'h5555_5555) random_access(1'b1, 8);
            else random_plain();
            send(1'b1, 1'b1);
        end
        drain();
        end_test("stall and flush mix", base);

        $display("%0d tests, %0d failed, %0d errors, %0d cycles", n_tests, n_failed, errors,
            cycle_cnt);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
